//--- lrelu_pkg.sv
`default_nettype none

package lrelu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath geometry.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int lanes      = 4;
  localparam int word_in_w  = 32;
  localparam int word_out_w = 8;

  // Alpha is an unsigned fraction of 128, so unity gain is 1 << alpha_w.
  localparam int alpha_w = 7;
  localparam int shift_w = 5;
  localparam int prod_w  = 40;

  // Configuration address map.
  localparam logic cfg_addr_alpha = 1'b0;
  localparam logic cfg_addr_shift = 1'b1;

  localparam logic [alpha_w-1:0] alpha_default = alpha_w'(13);
  localparam logic [shift_w-1:0] shift_default = shift_w'(0);

  typedef struct packed {
    logic [lanes-1:0][word_in_w-1:0] data;
    logic [lanes-1:0]                keep;
    logic                            last;
  } in_beat_t;

  typedef struct packed {
    logic [lanes-1:0][word_out_w-1:0] data;
    logic [lanes-1:0]                 keep;
    logic                             last;
  } out_beat_t;

endpackage

`default_nettype wire

//--- lrelu_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module lrelu_cfg_regs import lrelu_pkg::*; (
  input  wire logic               aclk,
  input  wire logic               rst_n,
  input  wire logic               cfg_req,
  input  wire logic               cfg_addr,
  input  wire logic [7:0]         cfg_wdata,
  output logic                    cfg_ack,
  output logic      [alpha_w-1:0] alpha,
  output logic      [shift_w-1:0] shift
);

  logic wr_en;

  // A request seen while ack is still low is the opening phase of a
  // handshake. It is taken exactly once because ack rises on the same edge.
  assign wr_en = cfg_req && !cfg_ack;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Four-phase acknowledge.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      cfg_ack <= 1'b0;
    end else if (wr_en) begin
      cfg_ack <= 1'b1;
    end else if (!cfg_req) begin
      cfg_ack <= 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register file.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      alpha <= alpha_default;
      shift <= shift_default;
    end else if (wr_en) begin
      // Upper write-data bits beyond each field are dropped.
      if (cfg_addr == cfg_addr_alpha) begin
        alpha <= cfg_wdata[alpha_w-1:0];
      end else if (cfg_addr == cfg_addr_shift) begin
        shift <= cfg_wdata[shift_w-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- axis_pipe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module axis_pipe_stage #(
  parameter type payload_t = logic
) (
  input  wire logic     aclk,
  input  wire logic     rst_n,
  input  wire payload_t s_data,
  input  wire logic     s_valid,
  output logic          s_ready,
  output payload_t      m_data,
  output logic          m_valid,
  input  wire logic     m_ready
);

  payload_t spill_data;
  logic     spill_valid;
  logic     in_fire;
  logic     main_free;
  logic     load_main;
  logic     load_spill;

  assign in_fire = s_valid && s_ready;

  // The main register can take a new beat if it is empty or being drained.
  assign main_free  = !m_valid || m_ready;
  assign load_main  = main_free && (spill_valid || in_fire);
  assign load_spill = in_fire && !main_free;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Occupancy and registered ready.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      m_valid     <= 1'b0;
      spill_valid <= 1'b0;
      s_ready     <= 1'b1;
    end else begin
      if (main_free) begin
        m_valid     <= spill_valid || in_fire;
        spill_valid <= 1'b0;
        s_ready     <= 1'b1;
      end else if (in_fire) begin
        // Main is stalled, so the beat in flight lands in the spill slot.
        spill_valid <= 1'b1;
        s_ready     <= 1'b0;
      end
    end
  end

  // Spill always drains ahead of new input to keep beats in order.
  always_ff @(posedge aclk) begin
    if (load_main) begin
      m_data <= spill_valid ? spill_data : s_data;
    end
    if (load_spill) begin
      spill_data <= s_data;
    end
  end

endmodule

`default_nettype wire

//--- lrelu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lrelu_unit import lrelu_pkg::*; (
  input  wire logic                         aclk,
  input  wire logic                         rst_n,
  input  wire logic                         en,
  input  wire logic signed [word_in_w-1:0]  x,
  input  wire logic        [alpha_w-1:0]    alpha,
  input  wire logic        [shift_w-1:0]    shift,
  output logic signed      [word_out_w-1:0] y
);

  logic        [alpha_w:0]      gain;
  logic signed [prod_w-1:0]     prod;
  logic        [shift_w:0]      sh;
  logic signed [prod_w-1:0]     round_c;
  logic signed [prod_w-1:0]     shifted;
  logic        [prod_w-word_out_w:0] hi_bits;
  logic signed [word_out_w-1:0] y_d;

  // Positive inputs pass at unity gain (128), negative ones are scaled by alpha.
  assign gain = x[word_in_w-1] ? {1'b0, alpha} : {1'b1, {alpha_w{1'b0}}};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage two: round half up, arithmetic shift, saturate.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign sh      = {1'b0, shift} + (shift_w+1)'(alpha_w);
  assign round_c = prod_w'(1) << (sh - 1'b1);
  assign shifted = (prod + round_c) >>> sh;
  assign hi_bits = shifted[prod_w-1:word_out_w-1];

  always_comb begin
    if (hi_bits == '0 || hi_bits == '1) begin
      y_d = shifted[word_out_w-1:0];
    end else if (shifted[prod_w-1]) begin
      y_d = {1'b1, {(word_out_w-1){1'b0}}};
    end else begin
      y_d = {1'b0, {(word_out_w-1){1'b1}}};
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      prod <= '0;
      y    <= '0;
    end else if (en) begin
      prod <= x * $signed({1'b0, gain});
      y    <= y_d;
    end
  end

endmodule

`default_nettype wire

//--- lrelu_array.sv
`timescale 1ns/1ps
`default_nettype none

module lrelu_array import lrelu_pkg::*; (
  input  wire logic               aclk,
  input  wire logic               rst_n,
  input  wire logic [alpha_w-1:0] alpha,
  input  wire logic [shift_w-1:0] shift,
  input  wire in_beat_t           s_data,
  input  wire logic               s_valid,
  output logic                    s_ready,
  output out_beat_t               m_data,
  output logic                    m_valid,
  input  wire logic               m_ready
);

  logic                             en;
  logic                             valid_q1;
  logic                             valid_q2;
  logic [lanes-1:0]                 keep_q1;
  logic [lanes-1:0]                 keep_q2;
  logic                             last_q1;
  logic                             last_q2;
  logic [lanes-1:0][word_out_w-1:0] y;

  // The whole array moves in lock step; a bubble in the last stage may be
  // overwritten even while downstream is stalled.
  assign en      = m_ready || !valid_q2;
  assign s_ready = en;
  assign m_valid = valid_q2;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      valid_q1 <= 1'b0;
      valid_q2 <= 1'b0;
    end else if (en) begin
      valid_q1 <= s_valid;
      valid_q2 <= valid_q1;
    end
  end

  always_ff @(posedge aclk) begin
    if (en) begin
      keep_q1 <= s_data.keep;
      keep_q2 <= keep_q1;
      last_q1 <= s_data.last;
      last_q2 <= last_q1;
    end
  end

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    lrelu_unit i_unit (
      .aclk  (aclk),
      .rst_n (rst_n),
      .en    (en),
      .x     (s_data.data[i]),
      .alpha (alpha),
      .shift (shift),
      .y     (y[i])
    );
  end

  always_comb begin
    m_data.keep = keep_q2;
    m_data.last = last_q2;
    for (int i = 0; i < lanes; i++) begin
      m_data.data[i] = keep_q2[i] ? y[i] : '0;
    end
  end

endmodule

`default_nettype wire

//--- axis_lrelu_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axis_lrelu_engine import lrelu_pkg::*; (
  input  wire logic                          aclk,
  input  wire logic                          rst_n,
  input  wire logic [lanes*word_in_w-1:0]    s_axis_tdata,
  input  wire logic [lanes-1:0]              s_axis_tkeep,
  input  wire logic                          s_axis_tlast,
  input  wire logic                          s_axis_tvalid,
  output logic                               s_axis_tready,
  output logic      [lanes*word_out_w-1:0]   m_axis_tdata,
  output logic      [lanes-1:0]              m_axis_tkeep,
  output logic                               m_axis_tlast,
  output logic                               m_axis_tvalid,
  input  wire logic                          m_axis_tready,
  input  wire logic                          cfg_req,
  input  wire logic                          cfg_addr,
  input  wire logic [7:0]                    cfg_wdata,
  output logic                               cfg_ack
);

  logic [alpha_w-1:0] alpha;
  logic [shift_w-1:0] shift;
  in_beat_t           s_beat;
  in_beat_t           in_beat;
  logic               in_valid;
  logic               in_ready;
  out_beat_t          out_beat;
  logic               out_valid;
  logic               out_ready;
  out_beat_t          m_beat;

  assign s_beat = '{data: s_axis_tdata, keep: s_axis_tkeep, last: s_axis_tlast};

  lrelu_cfg_regs i_cfg (
    .aclk, .rst_n, .cfg_req, .cfg_addr, .cfg_wdata, .cfg_ack, .alpha, .shift
  );

  axis_pipe_stage #(.payload_t(in_beat_t)) i_in_stage (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_data  (s_beat),
    .s_valid (s_axis_tvalid),
    .s_ready (s_axis_tready),
    .m_data  (in_beat),
    .m_valid (in_valid),
    .m_ready (in_ready)
  );

  lrelu_array i_array (
    .aclk, .rst_n, .alpha, .shift,
    .s_data  (in_beat),
    .s_valid (in_valid),
    .s_ready (in_ready),
    .m_data  (out_beat),
    .m_valid (out_valid),
    .m_ready (out_ready)
  );

  axis_pipe_stage #(.payload_t(out_beat_t)) i_out_stage (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_data  (out_beat),
    .s_valid (out_valid),
    .s_ready (out_ready),
    .m_data  (m_beat),
    .m_valid (m_axis_tvalid),
    .m_ready (m_axis_tready)
  );

  assign m_axis_tdata = m_beat.data;
  assign m_axis_tkeep = m_beat.keep;
  assign m_axis_tlast = m_beat.last;

endmodule

`default_nettype wire

//--- tb_lrelu_model.svh
`ifndef TB_LRELU_MODEL_SVH
`define TB_LRELU_MODEL_SVH

// One step of a 32-bit xorshift generator.
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Gain of 128 or alpha, then round half up by shift+7 and clamp to int8.
function automatic logic [word_out_w-1:0] lrelu_lane(input logic [word_in_w-1:0] x,
                                                     input logic [alpha_w-1:0] alpha,
                                                     input logic [shift_w-1:0] shift);
  longint xs;
  longint gain;
  longint res;
  int     sh;
  xs = longint'($signed(x));
  if (xs < 0) begin
    gain = alpha;
  end else begin
    gain = 128;
  end
  sh  = shift + 7;
  res = (xs * gain + (longint'(1) << (sh - 1))) >>> sh;
  if (res > 127) begin
    res = 127;
  end else if (res < -128) begin
    res = -128;
  end
  return res[word_out_w-1:0];
endfunction

// Lanes with keep low carry zero.
function automatic logic [lanes*word_out_w-1:0] lrelu_beat(
    input logic [lanes*word_in_w-1:0] data, input logic [lanes-1:0] keep,
    input logic [alpha_w-1:0] alpha, input logic [shift_w-1:0] shift);
  logic [lanes*word_out_w-1:0] y;
  y = '0;
  for (int i = 0; i < lanes; i++) begin
    if (keep[i]) begin
      y[i*word_out_w +: word_out_w] = lrelu_lane(data[i*word_in_w +: word_in_w], alpha, shift);
    end
  end
  return y;
endfunction

`endif

//--- tb_axis_lrelu_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axis_lrelu_engine import lrelu_pkg::*; ();

  localparam int n_basic      = 200;
  localparam int n_bp         = 300;
  localparam int n_rounds     = 4;
  localparam int n_cfg_beats  = 40;
  localparam int n_keep       = 60;
  localparam int total_beats  = n_basic + 1 + n_bp + n_rounds * n_cfg_beats + 6 + n_keep;
  localparam int cfg_cycles   = 4 * (2 * n_rounds + 6);
  localparam int timeout_lim  = 20 * (total_beats + cfg_cycles);
  localparam int exp_w        = 1 + lanes + lanes * word_out_w;

  logic                        aclk;
  logic                        rst_n;
  logic [lanes*word_in_w-1:0]  s_axis_tdata;
  logic [lanes-1:0]            s_axis_tkeep;
  logic                        s_axis_tlast;
  logic                        s_axis_tvalid;
  logic                        s_axis_tready;
  logic [lanes*word_out_w-1:0] m_axis_tdata;
  logic [lanes-1:0]            m_axis_tkeep;
  logic                        m_axis_tlast;
  logic                        m_axis_tvalid;
  logic                        m_axis_tready;
  logic                        cfg_req;
  logic                        cfg_addr;
  logic [7:0]                  cfg_wdata;
  logic                        cfg_ack;

  logic [31:0]        rng_state;
  logic [31:0]        ready_state;
  logic               random_ready;
  logic [alpha_w-1:0] cur_alpha;
  logic [shift_w-1:0] cur_shift;
  logic [exp_w-1:0]   exp_q[$];
  int                 errors;
  int                 cycle_count;

  `include "tb_lrelu_model.svh"

  axis_lrelu_engine i_dut (.*);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Random magnitude spread so that not every word saturates.
  function automatic logic [word_in_w-1:0] random_word();
    logic [31:0] r;
    r = next_rand();
    return $signed(r) >>> (next_rand() % 28);
  endfunction

  function automatic logic [lanes*word_in_w-1:0] random_data();
    logic [lanes*word_in_w-1:0] d;
    for (int i = 0; i < lanes; i++) begin
      d[i*word_in_w +: word_in_w] = random_word();
    end
    return d;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stream and configuration drivers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic send_beat(input logic [lanes*word_in_w-1:0] data,
                           input logic [lanes-1:0] keep, input logic last);
    s_axis_tdata  <= data;
    s_axis_tkeep  <= keep;
    s_axis_tlast  <= last;
    s_axis_tvalid <= 1'b1;
    @(posedge aclk);
    while (!s_axis_tready) begin
      @(posedge aclk);
    end
  endtask

  task automatic send_random(input int n, input bit rand_keep, input bit gaps);
    logic [31:0] r;
    for (int b = 0; b < n; b++) begin
      r = next_rand();
      if (gaps && r[9:8] == 2'b00) begin
        s_axis_tvalid <= 1'b0;
        @(posedge aclk);
      end
      send_beat(random_data(), rand_keep ? r[lanes-1:0] : '1, rand_keep ? r[4] : (b == n - 1));
    end
    s_axis_tvalid <= 1'b0;
  endtask

  task automatic send_extremes();
    send_beat({32'h0000_0080, 32'h0000_007f, 32'h8000_0000, 32'h7fff_ffff}, 4'hf, 1'b0);
    send_beat({32'hffff_ffff, 32'h0000_007e, 32'hffff_ff7e, 32'hffff_ff7f}, 4'hf, 1'b0);
    send_beat({32'hffff_ff80, 32'h7fff_fffe, 32'h8000_0001, 32'h0000_0000}, 4'hf, 1'b1);
    s_axis_tvalid <= 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge aclk);
    end
    repeat (4) @(posedge aclk);
  endtask

  // The first edge after raising req is where the DUT sees it.
  task automatic cfg_write(input logic addr, input logic [7:0] wdata);
    int n;
    cfg_addr  <= addr;
    cfg_wdata <= wdata;
    cfg_req   <= 1'b1;
    @(posedge aclk);
    check_value("cfg_ack", cfg_ack, 0);
    n = 0;
    do begin
      @(posedge aclk);
      n++;
    end while (!cfg_ack);
    check_value("cfg_ack rise delay", n, 1);
    cfg_req <= 1'b0;
    @(posedge aclk);
    check_value("cfg_ack", cfg_ack, 1);
    n = 0;
    do begin
      @(posedge aclk);
      n++;
    end while (cfg_ack);
    check_value("cfg_ack fall delay", n, 1);
  endtask

  task automatic set_config(input logic [alpha_w-1:0] alpha, input logic [shift_w-1:0] shift);
    logic [31:0] r;
    r = next_rand();
    cfg_write(cfg_addr_alpha, {r[7], alpha});
    cfg_write(cfg_addr_shift, {r[10:8], shift});
    cur_alpha = alpha;
    cur_shift = shift;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Scoreboard, back-pressure and watchdog.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge aclk) begin
    if (rst_n && s_axis_tvalid && s_axis_tready) begin
      exp_q.push_back({s_axis_tlast, s_axis_tkeep,
                       lrelu_beat(s_axis_tdata, s_axis_tkeep, cur_alpha, cur_shift)});
    end
  end

  always @(posedge aclk) begin : monitor
    logic [exp_w-1:0] expected;
    if (rst_n && m_axis_tvalid && m_axis_tready) begin
      if (exp_q.size() == 0) begin
        $display("Output beat at %0t arrived with no input beat left to match it", $time);
        errors++;
      end else begin
        expected = exp_q.pop_front();
        for (int i = 0; i < lanes; i++) begin
          check_value($sformatf("m_axis_tdata[%0d]", i), m_axis_tdata[i*word_out_w +: word_out_w],
                      expected[i*word_out_w +: word_out_w]);
        end
        check_value("m_axis_tkeep", m_axis_tkeep, expected[exp_w-2 -: lanes]);
        check_value("m_axis_tlast", m_axis_tlast, expected[exp_w-1]);
      end
    end
  end

  always @(posedge aclk) begin : ready_gen
    if (random_ready) begin
      ready_state = xorshift32(ready_state);
      m_axis_tready <= ready_state[12];
    end else begin
      m_axis_tready <= 1'b1;
    end
  end

  always @(posedge aclk) begin
    cycle_count++;
    if (cycle_count >= timeout_lim) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_lim);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    logic [31:0] r;
    int          n;
    rng_state     = 32'hfab;
    ready_state   = ~32'hfab;
    random_ready  = 1'b0;
    errors        = 0;
    cycle_count   = 0;
    cur_alpha     = alpha_default;
    cur_shift     = shift_default;
    rst_n         = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tkeep  = '0;
    s_axis_tlast  = 1'b0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b1;
    cfg_req       = 1'b0;
    cfg_addr      = 1'b0;
    cfg_wdata     = '0;
    repeat (4) @(posedge aclk);
    rst_n <= 1'b1;
    @(posedge aclk);
    check_value("m_axis_tvalid", m_axis_tvalid, 0);
    check_value("cfg_ack", cfg_ack, 0);
    check_value("s_axis_tready", s_axis_tready, 1);

    send_random(n_basic, 1'b0, 1'b0);
    drain();

    // Latency through an idle pipe.
    send_beat(random_data(), '1, 1'b1);
    s_axis_tvalid <= 1'b0;
    n = 0;
    do begin
      @(posedge aclk);
      n++;
    end while (!m_axis_tvalid);
    check_value("latency", n, 4);
    drain();

    random_ready <= 1'b1;
    send_random(n_bp, 1'b0, 1'b1);
    drain();
    for (int k = 0; k < n_rounds; k++) begin
      r = next_rand();
      set_config(r[6:0], r[15:8] % 25);
      send_random(n_cfg_beats, 1'b0, 1'b1);
      drain();
    end
    random_ready <= 1'b0;

    set_config(7'd127, 5'd0);
    send_extremes();
    drain();
    set_config(7'd0, 5'd0);
    send_extremes();
    drain();

    r = next_rand();
    set_config(r[6:0], r[15:8] % 25);
    send_random(n_keep, 1'b1, 1'b1);
    drain();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
lrelu_pkg.sv
lrelu_cfg_regs.sv
axis_pipe_stage.sv
lrelu_unit.sv
lrelu_array.sv
axis_lrelu_engine.sv
tb_axis_lrelu_engine.sv
